//--- flist.f
+incdir+.
mips_isa_pkg.sv
mips_pipe_pkg.sv
reg_file.sv
id_decode.sv
id2exe.sv
exe_stage.sv
mips_slice_top.sv
tb_clock_gen.sv
tb_mips_slice.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module tb_mips_slice
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mips_slice)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- tb_mips_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module tb_mips_slice;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               flush;
    logic               instr_valid;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] pc;
    logic               wb_valid;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_addr;
    logic [`DATA_W-1:0] wb_data;
    logic [`DATA_W-1:0] wb_pc;
    logic               wb_illegal;

    logic [`DATA_W-1:0] model_regs [`REG_N] = '{default: '0};
    logic [15:0]        lfsr_state = 16'd82;
    logic [`DATA_W-1:0] next_pc = 32'h0000_1000;
    int                 cyc = 0;
    int                 errors = 0;
    int                 checked = 0;

    // Accepted instruction still in the ID/EX register
    logic [`DATA_W-1:0] pend_ins;
    logic [`DATA_W-1:0] pend_pc;
    int                 pend_cyc;
    logic               pend_valid = 1'b0;

    // Expected results in program order
    logic [`DATA_W-1:0] exp_pc[$];
    logic [`DATA_W-1:0] exp_data[$];
    logic [`REG_AW-1:0] exp_addr[$];
    logic               exp_we[$];
    logic               exp_ill[$];
    int                 acc_cyc[$];

    // Results as the DUT delivered them
    logic [`DATA_W-1:0] got_pc[$];
    logic [`DATA_W-1:0] got_data[$];
    logic [`REG_AW-1:0] got_addr[$];
    logic               got_we[$];
    logic               got_ill[$];
    int                 got_cyc[$];

    mips_isa_pkg::funct_e fn_list [8] = '{
        mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU,
        mips_isa_pkg::FN_AND,  mips_isa_pkg::FN_OR,
        mips_isa_pkg::FN_XOR,  mips_isa_pkg::FN_SLT,
        mips_isa_pkg::FN_SLL,  mips_isa_pkg::FN_SRL
    };

    tb_clock_gen u_clock_gen (
        .clk_o (clk)
    );

    mips_slice_top dut0 (
        .clk_i         (clk),
        .rst_i         (rst),
        .stall_i       (stall),
        .flush_i       (flush),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .wb_valid_o    (wb_valid),
        .wb_we_o       (wb_we),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data),
        .wb_pc_o       (wb_pc),
        .wb_illegal_o  (wb_illegal)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [`REG_AW-1:0] pick_reg();
        return 5'(rand_bits(3) % 7 + 1); // r1 to r7 keeps dependencies dense
    endfunction

    function automatic logic [`DATA_W-1:0] enc_rtype(input mips_isa_pkg::funct_e fn,
                                                     input logic [`REG_AW-1:0] rs, rt, rd, sa);
        return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [`DATA_W-1:0] enc_itype(input mips_isa_pkg::opcode_e op,
                                                     input logic [`REG_AW-1:0] rs, rt,
                                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [`DATA_W-1:0] alu_ref(input mips_pipe_pkg::alu_op_e op,
                                                   input logic [`DATA_W-1:0] a, b,
                                                   input logic [`REG_AW-1:0] sa);
        case (op)
            mips_pipe_pkg::ALU_ADD: return a + b;
            mips_pipe_pkg::ALU_SUB: return a - b;
            mips_pipe_pkg::ALU_AND: return a & b;
            mips_pipe_pkg::ALU_OR:  return a | b;
            mips_pipe_pkg::ALU_XOR: return a ^ b;
            mips_pipe_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mips_pipe_pkg::ALU_SLL: return b << sa;
            mips_pipe_pkg::ALU_SRL: return b >> sa;
            mips_pipe_pkg::ALU_LUI: return {b[15:0], 16'h0000};
            default:                return '0;
        endcase
    endfunction

    // Executes one instruction on the model registers
    task automatic model_step(input logic [`DATA_W-1:0] ins, input logic [`DATA_W-1:0] ins_pc);
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`DATA_W-1:0]     res;
        logic [`REG_AW-1:0]     dst;
        logic                   ill;
        mips_pipe_pkg::alu_op_e op;
        a   = model_regs[ins[25:21]];
        b   = {16'h0000, ins[15:0]};
        dst = ins[20:16];
        ill = 1'b0;
        op  = mips_pipe_pkg::ALU_ADD;
        case (ins[31:26])
            mips_isa_pkg::OP_SPECIAL: begin
                b   = model_regs[ins[20:16]];
                dst = ins[15:11];
                case (ins[5:0])
                    mips_isa_pkg::FN_ADDU: op = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: op = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  op = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   op = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  op = mips_pipe_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  op = mips_pipe_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLL:  op = mips_pipe_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRL:  op = mips_pipe_pkg::ALU_SRL;
                    default:               ill = 1'b1;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: b = {{16{ins[15]}}, ins[15:0]};
            mips_isa_pkg::OP_SLTI: begin
                op = mips_pipe_pkg::ALU_SLT;
                b  = {{16{ins[15]}}, ins[15:0]};
            end
            mips_isa_pkg::OP_ANDI: op = mips_pipe_pkg::ALU_AND;
            mips_isa_pkg::OP_ORI:  op = mips_pipe_pkg::ALU_OR;
            mips_isa_pkg::OP_XORI: op = mips_pipe_pkg::ALU_XOR;
            mips_isa_pkg::OP_LUI:  op = mips_pipe_pkg::ALU_LUI;
            default:               ill = 1'b1;
        endcase
        res = alu_ref(op, a, b, ins[10:6]);
        if (!ill && dst != '0) begin
            model_regs[dst] = res;
        end
        exp_pc.push_back(ins_pc);
        exp_data.push_back(res);
        exp_addr.push_back(dst);
        exp_we.push_back(!ill);
        exp_ill.push_back(ill);
    endtask

    // An accepted instruction reaches the model when it leaves ID/EX unflushed
    always @(posedge clk) begin
        if (!rst) begin
            if (wb_valid && !stall) begin
                got_pc.push_back(wb_pc);
                got_data.push_back(wb_data);
                got_addr.push_back(wb_addr);
                got_we.push_back(wb_we);
                got_ill.push_back(wb_illegal);
                got_cyc.push_back(cyc);
            end
            if (!stall || flush) begin
                if (pend_valid && !flush) begin
                    model_step(pend_ins, pend_pc);
                    acc_cyc.push_back(pend_cyc);
                end
                pend_valid = 1'b0;
            end
            if (instr_valid && !stall && !flush) begin
                pend_ins   = instr;
                pend_pc    = pc;
                pend_cyc   = cyc;
                pend_valid = 1'b1;
            end
        end
        cyc = cyc + 1;
    end

    task automatic compare_data(input string what, input logic [`DATA_W-1:0] exp,
                                input logic [`DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_reg(input string what, input logic [`REG_AW-1:0] exp,
                               input logic [`REG_AW-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected r%0d, actual r%0d", what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", what, exp, act);
            errors++;
        end
    endtask

    task automatic issue(input logic [`DATA_W-1:0] ins, input int stalls, input logic flush_now);
        @(negedge clk);
        instr       = ins;
        pc          = next_pc;
        instr_valid = 1'b1;
        flush       = flush_now;
        stall       = (stalls > 0);
        next_pc     = next_pc + 4;
        repeat (stalls) @(negedge clk); // Source holds the instruction while stalled
        stall = 1'b0;
    endtask

    task automatic stall_idle(input int n);
        @(negedge clk);
        instr_valid = 1'b0;
        stall       = 1'b1;
        repeat (n) @(negedge clk);
        stall = 1'b0;
    endtask

    task automatic load_reg(input logic [`REG_AW-1:0] rd, input logic [`DATA_W-1:0] value);
        issue(enc_itype(mips_isa_pkg::OP_LUI, 5'd0, rd, value[31:16]), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_ORI, rd, rd, value[15:0]), 0, 1'b0);
    endtask

    // Each instruction reads the last two destinations, at distances 1 and 2
    task automatic issue_chain(input int n, input int stall_at, input int stall_len);
        logic [`REG_AW-1:0] prev1;
        logic [`REG_AW-1:0] prev2;
        logic [`REG_AW-1:0] rd;
        logic [`DATA_W-1:0] ins;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < n; i++) begin
            rd = pick_reg();
            if (i % 2 == 0) begin
                ins = enc_rtype(fn_list[3'(i)], prev1, prev2, rd, 5'(rand_bits(5)));
            end else begin
                ins = enc_rtype(fn_list[3'(i)], prev2, prev1, rd, 5'(rand_bits(5)));
            end
            issue(ins, (i == stall_at) ? stall_len : 0, 1'b0);
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    task automatic drain(input string name);
        int t;
        @(negedge clk);
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        t = 0;
        while ((pend_valid || got_pc.size() < exp_pc.size()) && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (pend_valid || got_pc.size() < exp_pc.size()) begin
            $display("%s: timed out waiting for results from the DUT", name);
            errors++;
        end
        repeat (4) @(negedge clk); // Any extra result would land here
    endtask

    task automatic check_results(input string name, input logic check_lat);
        int errs0;
        errs0 = errors;
        if (got_pc.size() != exp_pc.size()) begin
            $display("%s: expected %0d results but the DUT delivered %0d", name,
                     exp_pc.size(), got_pc.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_pc.size(); i++) begin
                compare_data({name, " pc"}, exp_pc[i], got_pc[i]);
                compare_flag({name, " illegal"}, exp_ill[i], got_ill[i]);
                compare_flag({name, " we"}, exp_we[i], got_we[i]);
                if (!exp_ill[i]) begin
                    compare_reg({name, " addr"}, exp_addr[i], got_addr[i]);
                    compare_data({name, " data"}, exp_data[i], got_data[i]);
                end
                if (check_lat) begin
                    compare_data({name, " latency"}, 32'(acc_cyc[i] + 2), 32'(got_cyc[i]));
                end
            end
        end
        $display("%s: %0d results, %0d errors", name, exp_pc.size(), errors - errs0);
        checked += exp_pc.size();
        exp_pc.delete();
        exp_data.delete();
        exp_addr.delete();
        exp_we.delete();
        exp_ill.delete();
        acc_cyc.delete();
        got_pc.delete();
        got_data.delete();
        got_addr.delete();
        got_we.delete();
        got_ill.delete();
        got_cyc.delete();
    endtask

    task automatic reset_idle();
        int errs0;
        errs0 = errors;
        repeat (4) begin
            @(negedge clk);
            compare_flag("reset wb_valid", 1'b0, wb_valid);
            compare_flag("reset wb_we", 1'b0, wb_we);
            compare_flag("reset wb_illegal", 1'b0, wb_illegal);
        end
        $display("reset: outputs idle, %0d errors", errors - errs0);
    endtask

    task automatic immediate_ops();
        load_reg(5'd1, rand_bits(32));
        issue(enc_itype(mips_isa_pkg::OP_LUI, 5'd0, 5'd2, 16'(rand_bits(16))), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_ORI, 5'd1, 5'd3, 16'(rand_bits(16))), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_ADDIU, 5'd1, 5'd4, {1'b1, 15'(rand_bits(15))}), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_ANDI, 5'd3, 5'd5, 16'(rand_bits(16))), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_XORI, 5'd4, 5'd6, 16'(rand_bits(16))), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_SLTI, 5'd4, 5'd7, 16'(rand_bits(16))), 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_SLTI, 5'd2, 5'd8, 16'h8000), 0, 1'b0);
        drain("immediates");
        check_results("immediates", 1'b1);
    endtask

    task automatic dependent_chains();
        for (int r = 1; r < 8; r++) begin
            load_reg(5'(r), rand_bits(32));
        end
        issue_chain(32, -1, 0);
        drain("chains");
        check_results("chains", 1'b1);
    endtask

    task automatic stall_midstream();
        for (int r = 1; r < 4; r++) begin
            load_reg(5'(r), rand_bits(32));
        end
        issue_chain(12, 4, 3);
        stall_idle(2); // Results still in flight
        issue_chain(6, 1, 1);
        drain("stall");
        check_results("stall", 1'b0);
    endtask

    task automatic flush_inflight();
        logic [`DATA_W-1:0] exe_pc;
        logic [`DATA_W-1:0] dec_pc;
        load_reg(5'd1, rand_bits(32));
        load_reg(5'd2, rand_bits(32));
        issue(enc_rtype(mips_isa_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 0, 1'b0);
        exe_pc = next_pc;
        issue(enc_rtype(mips_isa_pkg::FN_SUBU, 5'd1, 5'd2, 5'd4, 5'd0), 0, 1'b0);
        dec_pc = next_pc;
        issue(enc_itype(mips_isa_pkg::OP_ORI, 5'd1, 5'd5, 16'(rand_bits(16))), 0, 1'b1);
        issue(enc_rtype(mips_isa_pkg::FN_ADDU, 5'd5, 5'd0, 5'd6, 5'd0), 0, 1'b0);
        issue(enc_rtype(mips_isa_pkg::FN_OR, 5'd3, 5'd4, 5'd7, 5'd0), 0, 1'b0);
        issue(enc_rtype(mips_isa_pkg::FN_ADDU, 5'd5, 5'd0, 5'd2, 5'd0), 0, 1'b0);
        drain("flush");
        foreach (got_pc[i]) begin
            if (got_pc[i] == exe_pc || got_pc[i] == dec_pc) begin
                $display("flush: the instruction at pc %h was flushed but still delivered",
                         got_pc[i]);
                errors++;
            end
        end
        check_results("flush", 1'b0);
    endtask

    task automatic illegal_instr();
        load_reg(5'd3, rand_bits(32));
        issue({6'h3f, 5'd1, 5'd3, 16'(rand_bits(16))}, 0, 1'b0); // Reserved opcode, rt is r3
        issue(enc_rtype(mips_isa_pkg::FN_ADDU, 5'd3, 5'd0, 5'd4, 5'd0), 0, 1'b0);
        issue({mips_isa_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, 0, 1'b0);
        issue(enc_itype(mips_isa_pkg::OP_ORI, 5'd1, 5'd6, 16'h00ff), 0, 1'b0);
        issue(enc_rtype(mips_isa_pkg::FN_ADDU, 5'd3, 5'd0, 5'd5, 5'd0), 0, 1'b0);
        drain("illegal");
        check_results("illegal", 1'b1);
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        reset_idle();
        immediate_ops();
        dependent_chains();
        stall_midstream();
        flush_inflight();
        illegal_instr();
        $display("6 tests, %0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

endmodule

`default_nettype wire

//--- mips_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_slice_top (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               stall_i,
    input  wire logic               flush_i,
    input  wire logic               instr_valid_i,
    input  wire logic [`DATA_W-1:0] instr_i,
    input  wire logic [`DATA_W-1:0] pc_i,
    output logic                    wb_valid_o,
    output logic                    wb_we_o,
    output logic      [`REG_AW-1:0] wb_addr_o,
    output logic      [`DATA_W-1:0] wb_data_o,
    output logic      [`DATA_W-1:0] wb_pc_o,
    output logic                    wb_illegal_o
);

    logic [`DATA_W-1:0]       id_rdata1;
    logic [`DATA_W-1:0]       id_rdata2;
    logic [`DATA_W-1:0]       id_imm;
    logic [`REG_AW-1:0]       id_rs;
    logic [`REG_AW-1:0]       id_rt;
    logic [`REG_AW-1:0]       id_dst;
    logic [`REG_AW-1:0]       id_sa;
    mips_pipe_pkg::alu_op_e   id_alu_op;
    mips_pipe_pkg::opb_sel_e  id_opb_sel;
    logic                     id_wreg;
    logic                     id_illegal;

    logic                     ex_valid;
    logic [`DATA_W-1:0]       ex_pc;
    logic [`DATA_W-1:0]       ex_rdata1;
    logic [`DATA_W-1:0]       ex_rdata2;
    logic [`DATA_W-1:0]       ex_imm;
    logic [`REG_AW-1:0]       ex_rs;
    logic [`REG_AW-1:0]       ex_rt;
    logic [`REG_AW-1:0]       ex_dst;
    logic [`REG_AW-1:0]       ex_sa;
    mips_pipe_pkg::alu_op_e   ex_alu_op;
    mips_pipe_pkg::opb_sel_e  ex_opb_sel;
    logic                     ex_wreg;
    logic                     ex_illegal;

    logic                     rf_we;

    id_decode u_id_decode (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .instr_i    (instr_i),
        .rf_we_i    (rf_we),
        .rf_waddr_i (wb_addr_o), // Writeback loops back to the register file
        .rf_wdata_i (wb_data_o),
        .rdata1_o   (id_rdata1),
        .rdata2_o   (id_rdata2),
        .imm_o      (id_imm),
        .rs_o       (id_rs),
        .rt_o       (id_rt),
        .dst_o      (id_dst),
        .sa_o       (id_sa),
        .alu_op_o   (id_alu_op),
        .opb_sel_o  (id_opb_sel),
        .wreg_o     (id_wreg),
        .illegal_o  (id_illegal)
    );

    id2exe u_id2exe (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush_i),
        .stall_i   (stall_i),
        .valid_i   (instr_valid_i),
        .pc_i      (pc_i),
        .rdata1_i  (id_rdata1),
        .rdata2_i  (id_rdata2),
        .imm_i     (id_imm),
        .rs_i      (id_rs),
        .rt_i      (id_rt),
        .dst_i     (id_dst),
        .sa_i      (id_sa),
        .alu_op_i  (id_alu_op),
        .opb_sel_i (id_opb_sel),
        .wreg_i    (id_wreg),
        .illegal_i (id_illegal),
        .valid_o   (ex_valid),
        .pc_o      (ex_pc),
        .rdata1_o  (ex_rdata1),
        .rdata2_o  (ex_rdata2),
        .imm_o     (ex_imm),
        .rs_o      (ex_rs),
        .rt_o      (ex_rt),
        .dst_o     (ex_dst),
        .sa_o      (ex_sa),
        .alu_op_o  (ex_alu_op),
        .opb_sel_o (ex_opb_sel),
        .wreg_o    (ex_wreg),
        .illegal_o (ex_illegal)
    );

    exe_stage u_exe_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .valid_i      (ex_valid && !flush_i), // The instruction in execute is discarded too
        .pc_i         (ex_pc),
        .rdata1_i     (ex_rdata1),
        .rdata2_i     (ex_rdata2),
        .imm_i        (ex_imm),
        .rs_i         (ex_rs),
        .rt_i         (ex_rt),
        .dst_i        (ex_dst),
        .sa_i         (ex_sa),
        .alu_op_i     (ex_alu_op),
        .opb_sel_i    (ex_opb_sel),
        .wreg_i       (ex_wreg),
        .illegal_i    (ex_illegal),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_pc_o      (wb_pc_o),
        .wb_illegal_o (wb_illegal_o),
        .rf_we_o      (rf_we)
    );

endmodule

`default_nettype wire

//--- exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module exe_stage (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    stall_i,
    input  wire logic                    valid_i,
    input  wire logic [`DATA_W-1:0]      pc_i,
    input  wire logic [`DATA_W-1:0]      rdata1_i,
    input  wire logic [`DATA_W-1:0]      rdata2_i,
    input  wire logic [`DATA_W-1:0]      imm_i,
    input  wire logic [`REG_AW-1:0]      rs_i,
    input  wire logic [`REG_AW-1:0]      rt_i,
    input  wire logic [`REG_AW-1:0]      dst_i,
    input  wire logic [`REG_AW-1:0]      sa_i,
    input  wire mips_pipe_pkg::alu_op_e  alu_op_i,
    input  wire mips_pipe_pkg::opb_sel_e opb_sel_i,
    input  wire logic                    wreg_i,
    input  wire logic                    illegal_i,
    output logic                         wb_valid_o,
    output logic                         wb_we_o,
    output logic      [`REG_AW-1:0]      wb_addr_o,
    output logic      [`DATA_W-1:0]      wb_data_o,
    output logic      [`DATA_W-1:0]      wb_pc_o,
    output logic                         wb_illegal_o,
    output logic                         rf_we_o
);

    logic               wb_writes;
    logic [`DATA_W-1:0] opa;
    logic [`DATA_W-1:0] opb_reg;
    logic [`DATA_W-1:0] opb;
    logic [`DATA_W-1:0] alu_res;

    // Result register holds a committed write to a real register
    assign wb_writes = wb_valid_o && wb_we_o && (wb_addr_o != '0);

    assign opa     = (wb_writes && (wb_addr_o == rs_i)) ? wb_data_o : rdata1_i;
    assign opb_reg = (wb_writes && (wb_addr_o == rt_i)) ? wb_data_o : rdata2_i;
    assign opb     = (opb_sel_i == mips_pipe_pkg::OPB_IMM) ? imm_i : opb_reg;

    always_comb begin
        case (alu_op_i)
            mips_pipe_pkg::ALU_ADD: alu_res = opa + opb;
            mips_pipe_pkg::ALU_SUB: alu_res = opa - opb;
            mips_pipe_pkg::ALU_AND: alu_res = opa & opb;
            mips_pipe_pkg::ALU_OR:  alu_res = opa | opb;
            mips_pipe_pkg::ALU_XOR: alu_res = opa ^ opb;
            mips_pipe_pkg::ALU_SLT: alu_res = {{(`DATA_W-1){1'b0}}, $signed(opa) < $signed(opb)};
            mips_pipe_pkg::ALU_SLL: alu_res = opb << sa_i; // Shifts act on rt
            mips_pipe_pkg::ALU_SRL: alu_res = opb >> sa_i;
            mips_pipe_pkg::ALU_LUI: alu_res = {opb[15:0], 16'h0000};
            default:                alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o   <= 1'b0;
            wb_we_o      <= 1'b0;
            wb_addr_o    <= '0;
            wb_data_o    <= '0;
            wb_pc_o      <= '0;
            wb_illegal_o <= 1'b0;
        end else if (!stall_i) begin
            wb_valid_o   <= valid_i;
            wb_we_o      <= valid_i && wreg_i;
            wb_addr_o    <= dst_i;
            wb_data_o    <= alu_res;
            wb_pc_o      <= pc_i;
            wb_illegal_o <= valid_i && illegal_i;
        end
    end

    // Written once, at the edge where the result leaves writeback
    assign rf_we_o = wb_writes && !stall_i;

endmodule

`default_nettype wire

//--- id2exe.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module id2exe (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   flush_i,
    input  wire logic                   stall_i,
    input  wire logic                   valid_i,
    input  wire logic [`DATA_W-1:0]     pc_i,
    input  wire logic [`DATA_W-1:0]     rdata1_i,
    input  wire logic [`DATA_W-1:0]     rdata2_i,
    input  wire logic [`DATA_W-1:0]     imm_i,
    input  wire logic [`REG_AW-1:0]     rs_i,
    input  wire logic [`REG_AW-1:0]     rt_i,
    input  wire logic [`REG_AW-1:0]     dst_i,
    input  wire logic [`REG_AW-1:0]     sa_i,
    input  wire mips_pipe_pkg::alu_op_e alu_op_i,
    input  wire mips_pipe_pkg::opb_sel_e opb_sel_i,
    input  wire logic                   wreg_i,
    input  wire logic                   illegal_i,
    output logic                        valid_o,
    output logic      [`DATA_W-1:0]     pc_o,
    output logic      [`DATA_W-1:0]     rdata1_o,
    output logic      [`DATA_W-1:0]     rdata2_o,
    output logic      [`DATA_W-1:0]     imm_o,
    output logic      [`REG_AW-1:0]     rs_o,
    output logic      [`REG_AW-1:0]     rt_o,
    output logic      [`REG_AW-1:0]     dst_o,
    output logic      [`REG_AW-1:0]     sa_o,
    output mips_pipe_pkg::alu_op_e      alu_op_o,
    output mips_pipe_pkg::opb_sel_e     opb_sel_o,
    output logic                        wreg_o,
    output logic                        illegal_o
);

    // Flush has priority over stall
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_o   <= 1'b0;
            pc_o      <= '0;
            rdata1_o  <= '0;
            rdata2_o  <= '0;
            imm_o     <= '0;
            rs_o      <= '0;
            rt_o      <= '0;
            dst_o     <= '0;
            sa_o      <= '0;
            alu_op_o  <= mips_pipe_pkg::ALU_ADD;
            opb_sel_o <= mips_pipe_pkg::OPB_REG;
            wreg_o    <= 1'b0;
            illegal_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o   <= valid_i;
            pc_o      <= pc_i;
            rdata1_o  <= rdata1_i;
            rdata2_o  <= rdata2_i;
            imm_o     <= imm_i;
            rs_o      <= rs_i;
            rt_o      <= rt_i;
            dst_o     <= dst_i;
            sa_o      <= sa_i;
            alu_op_o  <= alu_op_i;
            opb_sel_o <= opb_sel_i;
            wreg_o    <= wreg_i;
            illegal_o <= illegal_i;
        end
    end

endmodule

`default_nettype wire

//--- id_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module id_decode (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic [`DATA_W-1:0]     instr_i,
    input  wire logic                   rf_we_i,
    input  wire logic [`REG_AW-1:0]     rf_waddr_i,
    input  wire logic [`DATA_W-1:0]     rf_wdata_i,
    output logic      [`DATA_W-1:0]     rdata1_o,
    output logic      [`DATA_W-1:0]     rdata2_o,
    output logic      [`DATA_W-1:0]     imm_o,
    output logic      [`REG_AW-1:0]     rs_o,
    output logic      [`REG_AW-1:0]     rt_o,
    output logic      [`REG_AW-1:0]     dst_o,
    output logic      [`REG_AW-1:0]     sa_o,
    output mips_pipe_pkg::alu_op_e      alu_op_o,
    output mips_pipe_pkg::opb_sel_e     opb_sel_o,
    output logic                        wreg_o,
    output logic                        illegal_o
);

    mips_isa_pkg::r_instr_t r_ins;
    mips_isa_pkg::i_instr_t i_ins;
    logic [`DATA_W-1:0]     imm_sext;
    logic [`DATA_W-1:0]     imm_zext;

    assign r_ins    = instr_i;
    assign i_ins    = instr_i;
    assign imm_sext = {{(`DATA_W-16){i_ins.imm[15]}}, i_ins.imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, i_ins.imm};

    assign rs_o = r_ins.rs;
    assign rt_o = r_ins.rt;
    assign sa_o = r_ins.sa;

    always_comb begin
        alu_op_o  = mips_pipe_pkg::ALU_ADD;
        opb_sel_o = mips_pipe_pkg::OPB_IMM; // I-type unless the opcode is SPECIAL
        dst_o     = i_ins.rt;
        imm_o     = imm_zext;
        wreg_o    = 1'b1;
        illegal_o = 1'b0;
        case (r_ins.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                opb_sel_o = mips_pipe_pkg::OPB_REG;
                dst_o     = r_ins.rd;
                case (r_ins.funct)
                    mips_isa_pkg::FN_ADDU: alu_op_o = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op_o = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op_o = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op_o = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op_o = mips_pipe_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  alu_op_o = mips_pipe_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLL:  alu_op_o = mips_pipe_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRL:  alu_op_o = mips_pipe_pkg::ALU_SRL;
                    default: begin
                        wreg_o    = 1'b0;
                        illegal_o = 1'b1;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDIU: imm_o = imm_sext;
            mips_isa_pkg::OP_SLTI: begin
                alu_op_o = mips_pipe_pkg::ALU_SLT;
                imm_o    = imm_sext;
            end
            mips_isa_pkg::OP_ANDI: alu_op_o = mips_pipe_pkg::ALU_AND;
            mips_isa_pkg::OP_ORI:  alu_op_o = mips_pipe_pkg::ALU_OR;
            mips_isa_pkg::OP_XORI: alu_op_o = mips_pipe_pkg::ALU_XOR;
            mips_isa_pkg::OP_LUI:  alu_op_o = mips_pipe_pkg::ALU_LUI;
            default: begin
                wreg_o    = 1'b0; // Reserved instruction writes nothing
                illegal_o = 1'b1;
            end
        endcase
    end

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (r_ins.rs),
        .raddr2_i (r_ins.rt),
        .waddr_i  (rf_waddr_i),
        .we_i     (rf_we_i),
        .wdata_i  (rf_wdata_i),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2_o)
    );

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module reg_file (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic [`REG_AW-1:0] raddr1_i,
    input  wire logic [`REG_AW-1:0] raddr2_i,
    input  wire logic [`REG_AW-1:0] waddr_i,
    input  wire logic               we_i,
    input  wire logic [`DATA_W-1:0] wdata_i,
    output logic      [`DATA_W-1:0] rdata1_o,
    output logic      [`DATA_W-1:0] rdata2_o
);

    logic [`DATA_W-1:0] regs [`REG_N];
    logic               wr_en;

    assign wr_en = we_i && (waddr_i != '0); // r0 is never written

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // A write in the same cycle is returned on the read port
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_en && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_en && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

//--- mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8 // Places the low half of operand B in the upper half
    } alu_op_e;

    typedef enum logic {
        OPB_REG = 1'b0,
        OPB_IMM = 1'b1
    } opb_sel_e;

endpackage

`default_nettype wire

//--- mips_isa_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, // R-type, decoded further by funct
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e             opcode;
        logic [`REG_AW-1:0]  rs;
        logic [`REG_AW-1:0]  rt;
        logic [`REG_AW-1:0]  rd;
        logic [`REG_AW-1:0]  sa;
        funct_e              funct;
    } r_instr_t;

    typedef struct packed {
        opcode_e             opcode;
        logic [`REG_AW-1:0]  rs;
        logic [`REG_AW-1:0]  rt;
        logic [15:0]         imm;
    } i_instr_t;

endpackage

`default_nettype wire

//--- mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and pc width
`define DATA_W 32

// Register index width and register count
`define REG_AW 5
`define REG_N 32

`endif
